/* list.f */
+incdir+rtl
rtl/board_pkg.sv
rtl/settle_filter.sv
rtl/pll_reconfig.sv
rtl/fb_descriptor.sv
rtl/activity_led.sv
rtl/board_ctrl_top.sv
sim/board_ctrl_assertions.sv
sim/tb_board_ctrl.sv

/* rtl/activity_led.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module activity_led #(
	parameter int unsigned hold_cycles = `LED_HOLD_CYCLES
) (
	input  logic clk_sys,
	input  logic cpu_reset,
	input  logic request,
	output logic led
);

	localparam int cnt_w = $clog2(hold_cycles + 1);

	logic [cnt_w-1:0] hold_cnt;

	// Each request restarts the full hold time
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			hold_cnt <= '0;
		end else if (request) begin
			hold_cnt <= cnt_w'(hold_cycles);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign led = (hold_cnt != '0);

endmodule

/* rtl/board_cfg.svh */
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// --------------------------------------------------
// PLL reconfiguration port
// --------------------------------------------------

// Register addresses of the reconfiguration block
`define PLL_ADDR_MODE   6'd0
`define PLL_ADDR_CDIV   6'd5
`define PLL_ADDR_START  6'd2

// UART clock divider words, one per UART speed mode
// Normal rate uses the widest divider
`define PLL_UDIV_NORMAL 32'h0004_f4f4
`define PLL_UDIV_FAST   32'h0004_0909
`define PLL_UDIV_MIDI   32'h0004_9696

// --------------------------------------------------
// Framebuffer
// --------------------------------------------------

// Upper 10 bits of the DDR address of the VGA memory window
`define FB_BASE_PREFIX  10'h0fe

// Fixed scan width in 24 bpp mode
`define FB_WIDTH_24BPP  12'd640

// Default activity LED hold time, about 50 ms at 90 MHz
`define LED_HOLD_CYCLES 32'd4500000

`endif

/* rtl/board_ctrl_top.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module board_ctrl_top
	import board_pkg::*;
#(
	parameter int unsigned led_hold = `LED_HOLD_CYCLES
) (
	input  logic        clk_sys,
	input  logic        cpu_reset,
	input  speed_sel_t  speed_sel,
	input  logic        uart_fast,
	input  logic        midi_en,
	input  logic        pll_locked,
	input  logic        cfg_waitrequest,
	output pll_cfg_wr_t cfg_wr,
	output clock_rate_t clock_rate,
	input  vga_mode_t   vga_mode,
	input  logic        fb_rgb,
	input  logic        fb_565,
	output fb_desc_t    fb,
	input  logic [7:0]  disk_req,
	output logic        led_disk,
	output logic        led_user
);

	// --------------------------------------------------
	// PLL reconfiguration and clock rate
	// --------------------------------------------------
	pll_reconfig pll_reconfig_i (
		.clk_sys         (clk_sys),
		.cpu_reset       (cpu_reset),
		.speed_sel       (speed_sel),
		.uart_fast       (uart_fast),
		.midi_en         (midi_en),
		.pll_locked      (pll_locked),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg_wr          (cfg_wr),
		.clock_rate      (clock_rate)
	);

	fb_descriptor fb_descriptor_i (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.vga_mode  (vga_mode),
		.fb_rgb    (fb_rgb),
		.fb_565    (fb_565),
		.fb        (fb)
	);

	// Hard disks on bits 5:0, floppy on bits 7:6
	activity_led #(.hold_cycles(led_hold)) hdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.request   (|disk_req[5:0]),
		.led       (led_disk)
	);

	activity_led #(.hold_cycles(led_hold)) fdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.request   (|disk_req[7:6]),
		.led       (led_user)
	);

endmodule

/* rtl/board_pkg.sv */
package board_pkg;

	// CPU speed index from the menu
	typedef logic [2:0] speed_sel_t;

	// UART divider mode
	typedef enum logic [1:0] {
		uart_speed_normal = 2'd0,
		uart_speed_fast   = 2'd1,
		uart_speed_midi   = 2'd2
	} uart_speed_t;

	// CPU clock rate in Hz
	typedef logic [27:0] clock_rate_t;

	// Write request towards the PLL reconfiguration port
	typedef struct packed {
		logic        write;
		logic [5:0]  address;
		logic [31:0] data;
	} pll_cfg_wr_t;

	// Mode outputs of the emulated graphics card
	// flags[1:0] colour mode, flags[2] text or planar, flags[3] line doubling
	typedef struct packed {
		logic [19:0] start_addr;
		logic [8:0]  width;
		logic [8:0]  stride;
		logic [10:0] height;
		logic [3:0]  flags;
		logic        off;
	} vga_mode_t;

	// Scaler framebuffer descriptor
	typedef struct packed {
		logic        en;
		logic [4:0]  fmt;
		logic [11:0] width;
		logic [11:0] height;
		logic [13:0] stride;
		logic [31:0] base;
		logic        off;
	} fb_desc_t;

	// --------------------------------------------------
	// Speed tables, indexed by speed_sel_t
	// --------------------------------------------------

	localparam clock_rate_t cpu_rate_table [0:7] = '{
		28'd90000000, 28'd15000000, 28'd30000000, 28'd56250000,
		28'd100000000, 28'd100000000, 28'd100000000, 28'd100000000
	};

	// Indices 4 to 7 all select the 100 MHz turbo setting
	localparam logic [31:0] cpu_div_table [0:7] = '{
		32'h0000_0505, 32'h0000_1e1e, 32'h0000_0f0f, 32'h0000_0808,
		32'h0002_0504, 32'h0002_0504, 32'h0002_0504, 32'h0002_0504
	};

endpackage

/* rtl/fb_descriptor.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module fb_descriptor
	import board_pkg::*;
(
	input  logic      clk_sys,
	input  logic      cpu_reset,
	input  vga_mode_t vga_mode,
	input  logic      fb_rgb,
	input  logic      fb_565,
	output fb_desc_t  fb
);

	logic [1:0] color_mode;
	logic       planar;
	logic       dbl_line;

	assign color_mode = vga_mode.flags[1:0];
	assign planar     = vga_mode.flags[2];
	assign dbl_line   = vga_mode.flags[3];

	always_ff @(posedge clk_sys) begin
		// Text and planar modes stay on the native VGA output
		if (cpu_reset) begin
			fb.en <= 1'b0;
		end else begin
			fb.en <= !planar && (color_mode != 2'd0);
		end
		fb.base   <= {`FB_BASE_PREFIX, vga_mode.start_addr, 2'b00};
		if (color_mode == 2'd3) begin
			fb.width <= `FB_WIDTH_24BPP;
		end else if (planar) begin
			fb.width <= {1'b0, vga_mode.width, 2'b00};
		end else begin
			fb.width <= {vga_mode.width, 3'b000};
		end
		fb.stride <= {2'b00, vga_mode.stride, 3'b000};
		// Line doubled modes scan each line twice
		fb.height <= dbl_line ? {2'b00, vga_mode.height[10:1]} : {1'b0, vga_mode.height};
		case (color_mode)
			2'd3:    fb.fmt[2:0] <= 3'b101;
			2'd2:    fb.fmt[2:0] <= 3'b100;
			default: fb.fmt[2:0] <= 3'b011;
		endcase
		fb.fmt[4:3] <= {~fb_rgb, ~fb_565};
		fb.off      <= vga_mode.off;
	end

endmodule

/* rtl/pll_reconfig.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module pll_reconfig
	import board_pkg::*;
(
	input  logic        clk_sys,
	input  logic        cpu_reset,
	input  speed_sel_t  speed_sel,
	input  logic        uart_fast,
	input  logic        midi_en,
	input  logic        pll_locked,
	input  logic        cfg_waitrequest,
	output pll_cfg_wr_t cfg_wr,
	output clock_rate_t clock_rate
);

	uart_speed_t uart_mode;
	uart_speed_t uart_settled;
	uart_speed_t uart_cap;
	speed_sel_t  speed_settled;
	speed_sel_t  speed_cap;
	logic [2:0]  step;
	logic        boot_pend;
	logic        rst_q;
	logic        start_req;
	logic [5:0]  wr_addr;
	logic [31:0] wr_data;
	logic [31:0] udiv;

	// MIDI rate overrides the menu setting
	assign uart_mode = midi_en ? uart_speed_midi :
		(uart_fast ? uart_speed_fast : uart_speed_normal);

	settle_filter #(.payload_t(speed_sel_t)) speed_filter (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.sample    (speed_sel),
		.settled   (speed_settled)
	);

	settle_filter #(.payload_t(uart_speed_t)) uart_filter (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.sample    (uart_mode),
		.settled   (uart_settled)
	);

	// Filters hold valid values one edge after reset release
	always_ff @(posedge clk_sys) begin
		rst_q <= cpu_reset;
	end

	assign start_req = (boot_pend && !rst_q) || (speed_settled != speed_cap) ||
		(uart_settled != uart_cap);

	// --------------------------------------------------
	// Write contents for the current step pair
	// --------------------------------------------------
	always_comb begin
		case (uart_cap)
			uart_speed_fast: udiv = `PLL_UDIV_FAST;
			uart_speed_midi: udiv = `PLL_UDIV_MIDI;
			default:         udiv = `PLL_UDIV_NORMAL;
		endcase
		case (step[2:1])
			2'd0: begin
				wr_addr = `PLL_ADDR_MODE;
				wr_data = '0;
			end
			2'd1: begin
				wr_addr = `PLL_ADDR_CDIV;
				wr_data = cpu_div_table[speed_cap];
			end
			2'd2: begin
				wr_addr = `PLL_ADDR_CDIV;
				wr_data = udiv;
			end
			default: begin
				wr_addr = `PLL_ADDR_START;
				wr_data = '0;
			end
		endcase
	end

	// Step 0 is idle; odd steps issue a write, even steps leave a gap
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			step      <= '0;
			cfg_wr    <= '0;
			boot_pend <= 1'b1;
			speed_cap <= '0;
			uart_cap  <= uart_speed_normal;
		end else if (!cfg_waitrequest) begin
			cfg_wr.write <= 1'b0;
			if (pll_locked) begin
				if (step != 3'd0) begin
					step <= step + 3'd1;
				end else if (start_req) begin
					step      <= 3'd1;
					speed_cap <= speed_settled;
					uart_cap  <= uart_settled;
					boot_pend <= 1'b0;
				end
				if (step[0]) begin
					cfg_wr <= '{write: 1'b1, address: wr_addr, data: wr_data};
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		clock_rate <= cpu_rate_table[speed_settled];
	end

endmodule

/* rtl/settle_filter.sv */
`timescale 1ns/1ps

module settle_filter #(
	parameter type payload_t = logic
) (
	input  logic     clk_sys,
	input  logic     cpu_reset,
	input  payload_t sample,
	output payload_t settled
);

	payload_t sample_q;
	payload_t sample_qq;

	// Sample history keeps running through reset
	always_ff @(posedge clk_sys) begin
		sample_q  <= sample;
		sample_qq <= sample_q;
	end

	// Only two equal consecutive samples reach the output
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			settled <= payload_t'(0);
		end else if (sample_q == sample_qq) begin
			settled <= sample_qq;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_board_ctrl -f list.f -o tb_board_ctrl \
	&& ./obj_dir/tb_board_ctrl | tee /dev/stderr | grep "TB PASSED" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* sim/board_ctrl_assertions.sv */
`timescale 1ns/1ps

module board_ctrl_assertions
	import board_pkg::*;
(
	input logic        clk_sys,
	input logic        cpu_reset,
	input logic        pll_locked,
	input logic        cfg_waitrequest,
	input pll_cfg_wr_t cfg_wr
);

	// --------------------------------------------------
	// PLL port handshake
	// --------------------------------------------------

	// A stalled request keeps address, data and write
	stall_hold: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		cfg_waitrequest |=> $stable(cfg_wr))
		else $error("PLL write request changed while wait request was high");

	no_write_in_reset: assert property (@(posedge clk_sys)
		cpu_reset |=> !cfg_wr.write)
		else $error("PLL write issued during reset");

	// New writes need a locked PLL
	no_write_unlocked: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		!pll_locked |=> !$rose(cfg_wr.write))
		else $error("PLL write issued while the PLL was not locked");

endmodule

bind pll_reconfig board_ctrl_assertions pll_assertions_i (
	.clk_sys         (clk_sys),
	.cpu_reset       (cpu_reset),
	.pll_locked      (pll_locked),
	.cfg_waitrequest (cfg_waitrequest),
	.cfg_wr          (cfg_wr)
);

/* sim/tb_board_ctrl.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module tb_board_ctrl
	import board_pkg::*;
();

	logic        clk_sys;
	logic        cpu_reset;
	speed_sel_t  speed_sel;
	logic        uart_fast;
	logic        midi_en;
	logic        pll_locked;
	logic        cfg_waitrequest;
	pll_cfg_wr_t cfg_wr;
	clock_rate_t clock_rate;
	vga_mode_t   vga_mode;
	logic        fb_rgb;
	logic        fb_565;
	fb_desc_t    fb;
	logic [7:0]  disk_req;
	logic        led_disk;
	logic        led_user;

	logic [31:0] rng_state = 32'h9c2;
	logic        stall_en;
	int          errors;
	int          checks;
	int          tests;
	int          failed_tests;
	speed_sel_t  model_speed;
	uart_speed_t model_mode;
	pll_cfg_wr_t writes_q [$];

	board_ctrl_top #(.led_hold(20)) dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Accepted PLL port writes are sampled between edges
	always @(negedge clk_sys) begin
		if (!cpu_reset && cfg_wr.write && !cfg_waitrequest) begin
			writes_q.push_back(cfg_wr);
		end
	end

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic logic [31:0] next_rand();
		logic [31:0] s;
		s = rng_state;
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		rng_state = s;
		return s;
	endfunction

	function automatic logic [31:0] cpu_div_of(input speed_sel_t s);
		case (s)
			3'd0:    return 32'h0000_0505;
			3'd1:    return 32'h0000_1e1e;
			3'd2:    return 32'h0000_0f0f;
			3'd3:    return 32'h0000_0808;
			default: return 32'h0002_0504;
		endcase
	endfunction

	function automatic clock_rate_t cpu_rate_of(input speed_sel_t s);
		case (s)
			3'd0:    return 28'd90_000_000;
			3'd1:    return 28'd15_000_000;
			3'd2:    return 28'd30_000_000;
			3'd3:    return 28'd56_250_000;
			default: return 28'd100_000_000;
		endcase
	endfunction

	function automatic uart_speed_t uart_mode_of(input logic fast, input logic midi);
		if (midi) begin
			return uart_speed_midi;
		end
		return fast ? uart_speed_fast : uart_speed_normal;
	endfunction

	function automatic logic [31:0] udiv_of(input uart_speed_t m);
		case (m)
			uart_speed_fast: return `PLL_UDIV_FAST;
			uart_speed_midi: return `PLL_UDIV_MIDI;
			default:         return `PLL_UDIV_NORMAL;
		endcase
	endfunction

	function automatic pll_cfg_wr_t cfg_write(input logic [5:0] addr, input logic [31:0] data);
		pll_cfg_wr_t w;
		w.write   = 1'b1;
		w.address = addr;
		w.data    = data;
		return w;
	endfunction

	function automatic fb_desc_t fb_model(input vga_mode_t m, input logic rgb, input logic c565);
		fb_desc_t   d;
		logic [1:0] cm;
		logic [2:0] low;
		cm = m.flags[1:0];
		d.en = !m.flags[2] && (cm != 2'd0);
		d.base = 32'(`FB_BASE_PREFIX) * 32'h0040_0000 + 32'(m.start_addr) * 32'd4;
		if (cm == 2'd3) begin
			d.width = `FB_WIDTH_24BPP;
		end else if (m.flags[2]) begin
			d.width = 12'(m.width) * 12'd4;
		end else begin
			d.width = 12'(m.width) * 12'd8;
		end
		d.stride = 14'(m.stride) * 14'd8;
		d.height = m.flags[3] ? 12'(m.height / 11'd2) : 12'(m.height);
		case (cm)
			2'd3:    low = 3'b101;
			2'd2:    low = 3'b100;
			default: low = 3'b011;
		endcase
		d.fmt = {!rgb, !c565, low};
		d.off = m.off;
		return d;
	endfunction

	function automatic logic led_of(input logic disk);
		return disk ? led_disk : led_user;
	endfunction

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_cfg(input string name, input pll_cfg_wr_t exp, input pll_cfg_wr_t act);
		checks++;
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_fb(input string name, input fb_desc_t exp, input fb_desc_t act);
		checks++;
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_rate(input string name, input clock_rate_t exp, input clock_rate_t act);
		checks++;
		if (act !== exp) begin
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_led(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// Timing helpers
	// --------------------------------------------------

	// Random wait request and lock loss while stalls are enabled
	task automatic next_edge();
		logic [31:0] r;
		@(posedge clk_sys);
		r = next_rand();
		cfg_waitrequest <= stall_en && (r[1:0] == 2'b00);
		pll_locked      <= !(stall_en && (r[3:2] == 2'b00));
	endtask

	task automatic wait_writes(input string name, input int n);
		int cycles;
		cycles = 0;
		while (writes_q.size() < n && cycles < 200) begin
			next_edge();
			cycles++;
		end
		if (writes_q.size() < n) begin
			$display("%s: timed out waiting for %0d PLL writes, saw %0d", name, n, writes_q.size());
			errors++;
		end
	endtask

	task automatic wait_led(input string name, input logic disk, input logic want, input int limit);
		int   n;
		logic seen;
		@(negedge clk_sys);
		n = 0;
		seen = led_of(disk);
		while (seen !== want && n < limit) begin
			next_edge();
			@(negedge clk_sys);
			seen = led_of(disk);
			n++;
		end
		if (seen !== want) begin
			$display("%s: LED did not go to %b within %0d cycles", name, want, limit);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// Test steps
	// --------------------------------------------------
	task automatic expect_sequence(input string name, input speed_sel_t s, input uart_speed_t m);
		pll_cfg_wr_t exp [4];
		exp[0] = cfg_write(`PLL_ADDR_MODE, 32'd0);
		exp[1] = cfg_write(`PLL_ADDR_CDIV, cpu_div_of(s));
		exp[2] = cfg_write(`PLL_ADDR_CDIV, udiv_of(m));
		exp[3] = cfg_write(`PLL_ADDR_START, 32'd0);
		wait_writes(name, 4);
		// No second sequence may follow in the quiet window
		repeat (24) next_edge();
		if (writes_q.size() != 4) begin
			$display("FAIL %s write count: expected 4, actual %0d", name, writes_q.size());
			errors++;
		end
		for (int i = 0; i < 4 && i < writes_q.size(); i++) begin
			check_cfg(name, exp[i], writes_q[i]);
		end
		writes_q.delete();
	endtask

	task automatic run_change(input string name, input speed_sel_t s, input logic fast,
		input logic midi);
		uart_speed_t m;
		m = uart_mode_of(fast, midi);
		next_edge();
		speed_sel <= s;
		uart_fast <= fast;
		midi_en   <= midi;
		if (s != model_speed || m != model_mode) begin
			expect_sequence(name, s, m);
			model_speed = s;
			model_mode  = m;
		end else begin
			repeat (24) next_edge();
			if (writes_q.size() != 0) begin
				$display("FAIL %s write count: expected 0, actual %0d", name, writes_q.size());
				errors++;
				writes_q.delete();
			end
		end
		@(negedge clk_sys);
		check_rate(name, cpu_rate_of(s), clock_rate);
	endtask

	task automatic led_pulse(input string name, input int idx, input logic disk);
		next_edge();
		disk_req <= 8'd1 << idx;
		next_edge();
		disk_req <= 8'd0;
		wait_led(name, disk, 1'b1, 2);
		repeat (8) next_edge();
		@(negedge clk_sys);
		check_led(name, 1'b1, led_of(disk));
		check_led(name, 1'b0, led_of(!disk));
		// A repeated request restarts the hold time
		next_edge();
		disk_req <= 8'd1 << idx;
		next_edge();
		disk_req <= 8'd0;
		repeat (15) next_edge();
		@(negedge clk_sys);
		check_led(name, 1'b1, led_of(disk));
		wait_led(name, disk, 1'b0, 6);
		check_led(name, 1'b0, led_of(!disk));
	endtask

	task automatic end_test(input string name, input int mark);
		tests++;
		if (errors == mark) begin
			$display("test %-12s ok", name);
		end else begin
			failed_tests++;
			$display("test %-12s failed with %0d errors", name, errors - mark);
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int          mark;
		logic [31:0] r;
		logic [31:0] r2;
		speed_sel_t  s;
		vga_mode_t   v;
		fb_desc_t    prev;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		stall_en = 1'b0;
		cpu_reset = 1'b1;
		pll_locked = 1'b1;
		cfg_waitrequest = 1'b0;
		disk_req = 8'd0;
		r = next_rand();
		r2 = next_rand();
		speed_sel = r[2:0];
		uart_fast = r[3];
		midi_en = r[4];
		fb_rgb = r[5];
		fb_565 = r[6];
		vga_mode = {r[31:10], r2};
		model_speed = speed_sel;
		model_mode = uart_mode_of(uart_fast, midi_en);

		mark = errors;
		repeat (7) next_edge();
		@(negedge clk_sys);
		check_cfg("reset", pll_cfg_wr_t'(0), cfg_wr);
		prev = fb_model(vga_mode, fb_rgb, fb_565);
		prev.en = 1'b0;
		check_fb("reset", prev, fb);
		check_led("reset", 1'b0, led_disk);
		check_led("reset", 1'b0, led_user);
		end_test("reset", mark);

		mark = errors;
		stall_en = 1'b1;
		next_edge();
		cpu_reset <= 1'b0;
		expect_sequence("boot", model_speed, model_mode);
		end_test("boot", mark);

		mark = errors;
		repeat (6) begin
			r = next_rand();
			s = r[2:0];
			if (s == model_speed) begin
				s = s + 3'd1;
			end
			run_change("speed_change", s, uart_fast, midi_en);
		end
		end_test("speed_change", mark);

		mark = errors;
		repeat (8) begin
			r = next_rand();
			run_change("uart_mode", speed_sel, r[0], r[1]);
		end
		end_test("uart_mode", mark);

		mark = errors;
		stall_en = 1'b0;
		repeat (20) begin
			r = next_rand();
			r2 = next_rand();
			v = {r[21:0], r2};
			prev = fb_model(vga_mode, fb_rgb, fb_565);
			next_edge();
			vga_mode <= v;
			fb_rgb   <= r[31];
			fb_565   <= r[30];
			@(negedge clk_sys);
			check_fb("fb_latency", prev, fb);
			next_edge();
			@(negedge clk_sys);
			check_fb("fb_desc", fb_model(v, r[31], r[30]), fb);
		end
		end_test("fb_desc", mark);

		mark = errors;
		r = next_rand();
		led_pulse("hdd_led", int'(r[7:0] % 8'd6), 1'b1);
		end_test("hdd_led", mark);
		mark = errors;
		led_pulse("fdd_led", 6 + int'(r[8]), 1'b0);
		end_test("fdd_led", mark);

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks,
			errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
